// File: hdl/isaPkg.sv
`default_nettype none

package isaPkg;

	typedef logic [15:0] word_t;
	typedef logic [3:0] regAddr_t;
	typedef logic [1:0] regPrefix_t;

	// top nibble of the instruction word
	typedef enum logic [3:0] {
		opLw   = 4'b0001,
		opSw   = 4'b0010,
		opJmp  = 4'b0011,
		opBeq  = 4'b0100,
		opBnq  = 4'b0101,
		opAdd  = 4'b1000,
		opAddi = 4'b1001,
		opNand = 4'b1011,
		opSub  = 4'b1100,
		opOr   = 4'b1111
	} opcode_t;

	// LW/SW base lives in r8..r11, data register in r12..r15
	localparam regPrefix_t baseRegPrefix = 2'b10;
	localparam regPrefix_t dataRegPrefix = 2'b11;

	typedef struct packed {
		opcode_t opcode;
		regAddr_t rs1;
		regAddr_t rs2;
		regAddr_t rd;
		regAddr_t baseReg;
		regAddr_t memReg;
		word_t simm8;
		word_t memOffset;
		word_t jumpOffset;
	} instrFields_t;

endpackage

`default_nettype wire

// File: hdl/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

	typedef enum logic [1:0] {
		aluAdd,
		aluSub,
		aluNand,
		aluOr
	} aluOp_t;

	typedef enum logic [1:0] {
		srcPc,
		srcRs1,
		srcRd,
		srcBase
	} srcA_t;

	typedef enum logic [2:0] {
		srcRs2,
		srcOne,
		srcSimm8,
		srcMemOffset,
		srcJumpOffset
	} srcB_t;

	typedef struct packed {
		aluOp_t aluOp;
		srcA_t srcA;
		srcB_t srcB;
		logic pcWrite;
		logic pcFromReg;
		logic branchEq;
		logic branchNe;
		logic irWrite;
		logic regWrite;
		logic regDstRd;
		logic memToReg;
		logic memRead;
		logic memWrite;
	} ctrlSig_t;

	// nothing written, nothing strobed
	localparam ctrlSig_t ctrlIdle = '{
		aluOp: aluAdd,
		srcA: srcPc,
		srcB: srcRs2,
		pcWrite: 1'b0,
		pcFromReg: 1'b0,
		branchEq: 1'b0,
		branchNe: 1'b0,
		irWrite: 1'b0,
		regWrite: 1'b0,
		regDstRd: 1'b0,
		memToReg: 1'b0,
		memRead: 1'b0,
		memWrite: 1'b0
	};

endpackage

`default_nettype wire

// File: hdl/instrDecode.sv
`timescale 1ns/100ps
`default_nettype none

module instrDecode (
	input wire clk,
	input wire rst,
	input wire isaPkg::word_t instr,
	input wire irWrite,
	output isaPkg::instrFields_t fields
);
	import isaPkg::*;

	word_t irReg;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			irReg <= '0;
		end else if (irWrite) begin
			irReg <= instr;
		end
	end

	always_comb begin
		fields.opcode = opcode_t'(irReg[15:12]);
		fields.rd = irReg[11:8];
		fields.rs1 = irReg[7:4];
		fields.rs2 = irReg[3:0];
		// memory ops name their registers by two bits each
		fields.baseReg = {baseRegPrefix, irReg[9:8]};
		fields.memReg = {dataRegPrefix, irReg[11:10]};
		fields.simm8 = {{8{irReg[7]}}, irReg[7:0]};
		// offset counts in half units, scaled up by one
		fields.memOffset = {{7{irReg[7]}}, irReg[7:0], 1'b0};
		fields.jumpOffset = {{4{irReg[11]}}, irReg[11:0]};
	end

endmodule

`default_nettype wire

// File: hdl/regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile (
	input wire clk,
	input wire rst,
	input wire isaPkg::instrFields_t fields,
	input wire regWrite,
	input wire regDstRd,
	input wire memToReg,
	input wire isaPkg::word_t aluOutReg,
	input wire isaPkg::word_t mdrReg,
	output isaPkg::word_t rs1Data,
	output isaPkg::word_t rs2Data,
	output isaPkg::word_t rdData,
	output isaPkg::word_t baseData,
	output isaPkg::word_t memDataReg
);
	import isaPkg::*;

	word_t regs [16];
	regAddr_t wrAddr;
	word_t wrData;

	assign wrAddr = regDstRd ? fields.rd : fields.memReg;
	assign wrData = memToReg ? mdrReg : aluOutReg;

	// r0 is never written, so it stays at its reset value of zero
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (regWrite && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

	assign rs1Data = regs[fields.rs1];
	assign rs2Data = regs[fields.rs2];
	assign rdData = regs[fields.rd];
	assign baseData = regs[fields.baseReg];
	assign memDataReg = regs[fields.memReg];

endmodule

`default_nettype wire

// File: hdl/executeUnit.sv
`timescale 1ns/100ps
`default_nettype none

module executeUnit #(
	parameter isaPkg::word_t resetPc = '0
) (
	input wire clk,
	input wire rst,
	input wire ctrlPkg::ctrlSig_t ctrl,
	input wire isaPkg::instrFields_t fields,
	input wire isaPkg::word_t rs1Data,
	input wire isaPkg::word_t rs2Data,
	input wire isaPkg::word_t rdData,
	input wire isaPkg::word_t baseData,
	input wire isaPkg::word_t dataRdData,
	output isaPkg::word_t instrAddr,
	output isaPkg::word_t aluOutReg,
	output isaPkg::word_t mdrReg
);
	import isaPkg::*;
	import ctrlPkg::*;

	word_t pc;
	word_t opA;
	word_t opB;
	word_t aluResult;
	logic zero;
	logic branchTaken;

	always_comb begin
		case (ctrl.srcA)
			srcRs1: opA = rs1Data;
			srcRd: opA = rdData;
			srcBase: opA = baseData;
			default: opA = pc;
		endcase
		case (ctrl.srcB)
			srcOne: opB = 16'd1;
			srcSimm8: opB = fields.simm8;
			srcMemOffset: opB = fields.memOffset;
			srcJumpOffset: opB = fields.jumpOffset;
			default: opB = rs2Data;
		endcase
	end

	always_comb begin
		case (ctrl.aluOp)
			aluSub: aluResult = opA - opB;
			aluNand: aluResult = ~(opA & opB);
			aluOr: aluResult = opA | opB;
			default: aluResult = opA + opB;
		endcase
	end

	assign zero = (aluResult == '0);
	assign branchTaken = (ctrl.branchEq && zero) || (ctrl.branchNe && !zero);

	// branch target is the register named by rd
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= resetPc;
		end else if (ctrl.pcWrite) begin
			pc <= aluResult;
		end else if (ctrl.pcFromReg && branchTaken) begin
			pc <= rdData;
		end
	end

	always_ff @(posedge clk) begin
		aluOutReg <= aluResult;
		mdrReg <= dataRdData;
	end

	assign instrAddr = pc;

endmodule

`default_nettype wire

// File: hdl/cpuControl.sv
`timescale 1ns/100ps
`default_nettype none

module cpuControl (
	input wire clk,
	input wire rst,
	input wire isaPkg::opcode_t opcode,
	output ctrlPkg::ctrlSig_t ctrl
);
	import isaPkg::*;
	import ctrlPkg::*;

	typedef enum logic [3:0] {
		fetch,
		decode,
		exR,
		exAddi,
		exBranchEq,
		exBranchNe,
		exJmp,
		exMem,
		memLoad,
		memStore,
		writeAlu,
		writeLoad
	} state_t;

	state_t state;
	state_t nextState;

	function automatic aluOp_t rTypeOp(opcode_t op);
		case (op)
			opSub: return aluSub;
			opNand: return aluNand;
			opOr: return aluOr;
			default: return aluAdd;
		endcase
	endfunction

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= fetch;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = fetch;
		case (state)
			fetch: nextState = decode;
			decode: begin
				case (opcode)
					opAdd, opSub, opNand, opOr: nextState = exR;
					opAddi: nextState = exAddi;
					opBeq: nextState = exBranchEq;
					opBnq: nextState = exBranchNe;
					opJmp: nextState = exJmp;
					opLw, opSw: nextState = exMem;
					// unknown opcode falls back to fetch
					default: nextState = fetch;
				endcase
			end
			exR, exAddi: nextState = writeAlu;
			exMem: nextState = (opcode == opLw) ? memLoad : memStore;
			memLoad: nextState = writeLoad;
			default: nextState = fetch;
		endcase
	end

	always_comb begin
		ctrl = ctrlIdle;
		case (state)
			fetch: begin
				// pc + 1 while the instruction register loads
				ctrl.srcB = srcOne;
				ctrl.pcWrite = 1'b1;
				ctrl.irWrite = 1'b1;
			end
			exR: begin
				ctrl.aluOp = rTypeOp(opcode);
				ctrl.srcA = srcRs1;
			end
			exAddi: begin
				ctrl.srcA = srcRd;
				ctrl.srcB = srcSimm8;
			end
			exBranchEq, exBranchNe: begin
				ctrl.aluOp = aluSub;
				ctrl.srcA = srcRs1;
				ctrl.pcFromReg = 1'b1;
				ctrl.branchEq = (state == exBranchEq);
				ctrl.branchNe = (state == exBranchNe);
			end
			exJmp: begin
				ctrl.srcB = srcJumpOffset;
				ctrl.pcWrite = 1'b1;
			end
			exMem: begin
				ctrl.srcA = srcBase;
				ctrl.srcB = srcMemOffset;
			end
			memLoad: ctrl.memRead = 1'b1;
			memStore: ctrl.memWrite = 1'b1;
			writeAlu: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDstRd = 1'b1;
			end
			writeLoad: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
			end
			default: ctrl = ctrlIdle;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/cpuTop.sv
`timescale 1ns/100ps
`default_nettype none

module cpuTop #(
	parameter isaPkg::word_t resetPc = '0
) (
	input wire clk,
	input wire rst,
	input wire isaPkg::word_t instr,
	output isaPkg::word_t instrAddr,
	output isaPkg::word_t dataAddr,
	output isaPkg::word_t dataWrData,
	output logic dataWrite,
	output logic dataRead,
	input wire isaPkg::word_t dataRdData
);
	import isaPkg::*;
	import ctrlPkg::*;

	ctrlSig_t ctrl;
	instrFields_t fields;
	word_t rs1Data;
	word_t rs2Data;
	word_t rdData;
	word_t baseData;
	word_t memDataReg;
	word_t aluOutReg;
	word_t mdrReg;

	cpuControl cpuControl_i (
		.clk(clk),
		.rst(rst),
		.opcode(fields.opcode),
		.ctrl(ctrl)
	);

	instrDecode instrDecode_i (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.irWrite(ctrl.irWrite),
		.fields(fields)
	);

	regFile regFile_i (
		.clk(clk),
		.rst(rst),
		.fields(fields),
		.regWrite(ctrl.regWrite),
		.regDstRd(ctrl.regDstRd),
		.memToReg(ctrl.memToReg),
		.aluOutReg(aluOutReg),
		.mdrReg(mdrReg),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data),
		.rdData(rdData),
		.baseData(baseData),
		.memDataReg(memDataReg)
	);

	executeUnit #(
		.resetPc(resetPc)
	) executeUnit_i (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl),
		.fields(fields),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data),
		.rdData(rdData),
		.baseData(baseData),
		.dataRdData(dataRdData),
		.instrAddr(instrAddr),
		.aluOutReg(aluOutReg),
		.mdrReg(mdrReg)
	);

	// address was computed in exMem and held in the result register
	assign dataAddr = aluOutReg;
	assign dataWrData = memDataReg;
	assign dataWrite = ctrl.memWrite;
	assign dataRead = ctrl.memRead;

endmodule

`default_nettype wire

// File: sim/cpuTop_properties.sv
`timescale 1ns/100ps
`default_nettype none

module cpuTop_properties (
	input wire clk,
	input wire rst,
	input wire dataWrite,
	input wire dataRead
);

	// a memory cycle is either a load or a store
	strobesExclusive: assert property (@(posedge clk) disable iff (rst)
		!(dataWrite && dataRead))
		else $error("dataWrite and dataRead high in the same cycle");

	writeSingleCycle: assert property (@(posedge clk) disable iff (rst)
		dataWrite |=> !dataWrite)
		else $error("dataWrite high for two cycles in a row");

	// first cycle out of reset is a fetch
	idleAfterReset: assert property (@(posedge clk) $fell(rst) |-> !dataWrite && !dataRead)
		else $error("memory strobe active in the cycle after reset");

endmodule

bind cpuTop cpuTop_properties cpuTop_properties_i (
	.clk(clk),
	.rst(rst),
	.dataWrite(dataWrite),
	.dataRead(dataRead)
);

`default_nettype wire

// File: sim/cpuTop_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cpuTop_tb;
	import isaPkg::*;

	typedef enum logic [3:0] {
		tLoadStore, tAdd, tSub, tNand, tOr, tAddiNeg, tAddiPos,
		tBeqEq, tBeqNe, tBnqEq, tBnqNe, tJmp
	} testKind_t;

	typedef struct packed {
		testKind_t kind;
		word_t a;
		word_t b;
		word_t expected;
	} testRow_t;

	localparam int numTests = 12;
	localparam int runMargin = 3;
	localparam logic [7:0] immNeg = 8'hF3;
	localparam logic [7:0] immPos = 8'h25;

	logic clk = 1'b0;
	logic rst;
	word_t instr;
	word_t instrAddr;
	word_t dataAddr;
	word_t dataWrData;
	logic dataWrite;
	logic dataRead;
	word_t dataRdData;

	word_t imem [64];
	word_t dmem [64];
	word_t dmemInit [64];
	testKind_t kindList [numTests] = '{tLoadStore, tAdd, tSub, tNand, tOr, tAddiNeg,
		tAddiPos, tBeqEq, tBeqNe, tBnqEq, tBnqNe, tJmp};
	testRow_t testTable [numTests];
	int progLen;
	int progCycles;
	int cycleLimit;
	int activeCycles = 0;
	int errorCount;
	int failedTests;
	logic [31:0] lcgState;

	cpuTop cpuTop_i (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.instrAddr(instrAddr),
		.dataAddr(dataAddr),
		.dataWrData(dataWrData),
		.dataWrite(dataWrite),
		.dataRead(dataRead),
		.dataRdData(dataRdData)
	);

	assign instr = imem[instrAddr[5:0]];
	// read data only shows up while the read strobe is high
	assign dataRdData = dataRead ? dmem[dataAddr[5:0]] : '0;

	always #10 clk = ~clk;

	// data memory reloads from dmemInit while reset is held
	always @(posedge clk) begin
		if (rst) begin
			dmem <= dmemInit;
		end else if (dataWrite) begin
			dmem[dataAddr[5:0]] <= dataWrData;
		end
	end

	always @(posedge clk) begin
		if (!rst) begin
			activeCycles <= activeCycles + 1;
			if (activeCycles >= cycleLimit) begin
				$display("timeout: programs still running after %0d cycles", activeCycles);
				$display("CHECKS FAILED");
				$finish;
			end
		end
	end

	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic int instrCycles(input word_t word);
		case (word[15:12])
			opLw: return 5;
			opSw, opAdd, opSub, opNand, opOr, opAddi: return 4;
			opBeq, opBnq, opJmp: return 3;
			default: return 2;
		endcase
	endfunction

	// value expected in the checked data word
	function automatic word_t expectedWord(input testKind_t kind, input word_t a, input word_t b);
		case (kind)
			tAdd: return a + b;
			tSub: return a - b;
			tNand: return ~(a & b);
			tOr: return a | b;
			tAddiNeg: return a + {{8{immNeg[7]}}, immNeg};
			tAddiPos: return a + {{8{immPos[7]}}, immPos};
			// taken branch or jump skips the marker store
			tBeqEq, tBnqNe, tJmp: return ~a;
			tBeqNe, tBnqEq: return a;
			default: return b;
		endcase
	endfunction

	// rd r3, rs1 r12, rs2 r13
	function automatic word_t aluWord(input testKind_t kind);
		case (kind)
			tSub: return 16'hC3CD;
			tNand: return 16'hB3CD;
			tOr: return 16'hF3CD;
			default: return 16'h83CD;
		endcase
	endfunction

	// target in r5, equal case compares r12 with itself, unequal r9 with r0
	function automatic word_t branchWord(input testKind_t kind);
		case (kind)
			tBeqEq: return 16'h45CC;
			tBeqNe: return 16'h4590;
			tBnqEq: return 16'h55CC;
			default: return 16'h5590;
		endcase
	endfunction

	task automatic emit(input word_t word);
		imem[progLen[5:0]] = word;
		progLen++;
		progCycles += instrCycles(word);
	endtask

	task automatic buildProgram(input testKind_t kind);
		foreach (imem[i]) imem[i] = '0;
		progLen = 0;
		progCycles = 0;
		// LW r12 from word 0, then r9 = 1 so it can base odd words
		emit(16'h1000);
		emit(16'h9901);
		case (kind)
			tLoadStore: begin
				emit(16'h1500);
				emit(16'h2002);
				emit(16'h2502);
			end
			tAdd, tSub, tNand, tOr: begin
				emit(16'h1500);
				emit(aluWord(kind));
				emit(16'h8E30);
				emit(16'h2803);
			end
			tAddiNeg, tAddiPos: begin
				emit({8'h9C, ((kind == tAddiNeg) ? immNeg : immPos)});
				emit(16'h2003);
			end
			tJmp: begin
				emit(16'h3001);
				emit(16'h2103);
				emit(16'h2003);
			end
			default: begin
				// r5 = 5, the address just past the marker store
				emit(16'h9505);
				emit(branchWord(kind));
				emit(16'h2103);
			end
		endcase
		// halt, a jump to itself
		emit(16'h3FFF);
	endtask

	task automatic checkValue(input string name, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
			errorCount++;
		end
	endtask

	task automatic checkResults(input testRow_t row);
		case (row.kind)
			tLoadStore: begin
				checkValue("dmem[4]", dmem[4], row.a);
				checkValue("dmem[5]", dmem[5], row.expected);
			end
			tBeqEq, tBeqNe, tBnqEq, tBnqNe: checkValue("dmem[7]", dmem[7], row.expected);
			tJmp: begin
				checkValue("dmem[7]", dmem[7], row.expected);
				checkValue("dmem[6]", dmem[6], row.a);
			end
			default: checkValue("dmem[6]", dmem[6], row.expected);
		endcase
	endtask

	initial begin
		testRow_t row;
		int errorsBefore;
		rst = 1'b1;
		errorCount = 0;
		failedTests = 0;
		lcgState = 32'd73;
		cycleLimit = 50;
		foreach (dmemInit[i]) dmemInit[i] = '0;
		foreach (imem[i]) imem[i] = '0;
		foreach (testTable[i]) begin
			testTable[i].kind = kindList[i];
			lcgState = lcgNext(lcgState);
			testTable[i].a = lcgState[31:16];
			lcgState = lcgNext(lcgState);
			testTable[i].b = lcgState[31:16];
			testTable[i].expected = expectedWord(kindList[i], testTable[i].a, testTable[i].b);
			buildProgram(kindList[i]);
			cycleLimit += progCycles + runMargin;
		end
		foreach (testTable[i]) begin
			row = testTable[i];
			errorsBefore = errorCount;
			rst = 1'b1;
			dmemInit[0] = row.a;
			dmemInit[1] = row.b;
			// word 7 starts as the inverse of the marker
			dmemInit[7] = ~row.a;
			buildProgram(row.kind);
			repeat (10) @(posedge clk);
			#2 rst = 1'b0;
			repeat (progCycles + runMargin) @(posedge clk);
			#2;
			checkResults(row);
			if (errorCount == errorsBefore) begin
				$display("test %0d %s: ok", i, row.kind.name());
			end else begin
				$display("test %0d %s: wrong result", i, row.kind.name());
				failedTests++;
			end
		end
		$display("%0d tests, %0d with errors, %0d mismatches", numTests, failedTests, errorCount);
		if (errorCount == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: cpuTop.f
hdl/isaPkg.sv
hdl/ctrlPkg.sv
hdl/instrDecode.sv
hdl/regFile.sv
hdl/executeUnit.sv
hdl/cpuControl.sv
hdl/cpuTop.sv
sim/cpuTop_properties.sv
sim/cpuTop_tb.sv

// File: Makefile
# Verilator build and run of the cpuTop testbench

VERILATOR ?= verilator
TOP ?= cpuTop_tb
FILELIST ?= cpuTop.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps
PASS_MSG ?= ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass message in $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
